// File: flist.f
+incdir+hw
hw/ahb_pkg.sv
hw/timer_pkg.sv
hw/ahb_slot_decoder.sv
hw/ahb_timer.sv
hw/ahb_resp_mux.sv
hw/timer_subsys_top.sv
test/timer_checker.sv
test/tb_timer_subsys.sv

// File: hw/ahb_pkg.sv
// AHB-Lite bus types
// Address and data words, transfer encoding, per-slot request, error FSM states

`include "soc_cfg.svh"

package ahb_pkg;

   typedef logic [`HADDR_W-1:0] haddr_t;
   typedef logic [`HDATA_W-1:0] hdata_t;

   // HTRANS encoding
   typedef enum logic [1:0] {
      IDLE   = 2'b00,
      BUSY   = 2'b01,
      NONSEQ = 2'b10,
      SEQ    = 2'b11
   } htrans_e;

   // Address-phase request as seen by one slot
   typedef struct packed {
      logic       sel;     // Valid transfer, HREADY high, window hit
      logic       write;
      logic [1:0] word;    // haddr[3:2]
   } ahb_req_t;

   // Default-slave states for the two-cycle ERROR response
   typedef enum logic [1:0] {
      ERR_IDLE   = 2'b00,
      ERR_FIRST  = 2'b01,   // hready low, hresp high
      ERR_SECOND = 2'b10    // hready high, hresp high
   } err_state_e;

endpackage

// File: hw/ahb_resp_mux.sv
// Data-phase response path
// Owner slot register, read-data select, HREADY and HRESP shaping

`timescale 1ns/1ps
`include "soc_cfg.svh"

module ahb_resp_mux (
   input  logic                  hclk_i,
   input  logic                  reset_i,
   input  logic [`TMR_SLOTS-1:0] slot_hit_i,
   input  ahb_pkg::err_state_e   err_state_i,
   input  ahb_pkg::hdata_t       slot_rdata_i [`TMR_SLOTS],
   output ahb_pkg::hdata_t       hrdata_o,
   output logic                  hready_o,
   output logic                  hresp_o
);

   import ahb_pkg::*;
   import timer_pkg::*;

   typedef struct packed {
      logic      vld;
      slot_idx_t idx;
   } owner_t;

   owner_t owner_d;
   owner_t owner_q;

   // One-hot hit to slot index
   always_comb begin
      owner_d = '0;
      for (int i = 0; i < `TMR_SLOTS; i++) begin
         if (slot_hit_i[i]) begin
            owner_d.vld = 1'b1;
            owner_d.idx = slot_idx_t'(i);
         end
      end
   end

   always_ff @(posedge hclk_i) begin
      if (reset_i) begin
         owner_q <= '0;
      end else begin
         owner_q <= owner_d;     // Hits are already gated by HREADY
      end
   end

   assign hrdata_o = owner_q.vld ? slot_rdata_i[owner_q.idx] : '0;

   // Only the first error cycle stalls the bus
   assign hready_o = (err_state_i != ERR_FIRST);
   assign hresp_o  = (err_state_i != ERR_IDLE);

endmodule

// File: hw/ahb_slot_decoder.sv
// Address-phase decoder for the timer slots
// Mask-and-base window match, qualified per-slot requests, default-slave FSM

`timescale 1ns/1ps
`include "soc_cfg.svh"

module ahb_slot_decoder (
   input  logic                  hclk_i,
   input  logic                  reset_i,
   input  ahb_pkg::haddr_t       haddr_i,
   input  ahb_pkg::htrans_e      htrans_i,
   input  logic                  hwrite_i,
   input  logic                  hready_i,
   output ahb_pkg::ahb_req_t     slot_req_o [`TMR_SLOTS],
   output logic [`TMR_SLOTS-1:0] slot_hit_o,
   output ahb_pkg::err_state_e   err_state_o
);

   import ahb_pkg::*;
   import timer_pkg::*;

   logic                  xfer_ok;    // Address phase accepted this edge
   logic [`TMR_SLOTS-1:0] win_hit;
   logic                  unmapped;
   err_state_e            err_state_q;
   err_state_e            err_state_d;

   function automatic haddr_t slot_base(input slot_idx_t idx);
      return `TMR_BASE + haddr_t'(idx) * `TMR_STRIDE;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Window match

   // Only NONSEQ and SEQ count, and only while the bus is ready
   assign xfer_ok = hready_i && (htrans_i == NONSEQ || htrans_i == SEQ);

   for (genvar i = 0; i < `TMR_SLOTS; i++) begin : g_slot
      assign win_hit[i] = (haddr_i & `TMR_MASK) == slot_base(slot_idx_t'(i));

      assign slot_req_o[i] = '{sel:   xfer_ok & win_hit[i],
                               write: hwrite_i,
                               word:  haddr_i[3:2]};
   end

   assign slot_hit_o = win_hit & {`TMR_SLOTS{xfer_ok}};   // One-hot or zero
   assign unmapped   = xfer_ok & ~(|win_hit);

   ////////////////////////////////////////////////////////////////////////////
   // Default slave

   always_comb begin
      err_state_d = err_state_q;
      case (err_state_q)
         ERR_IDLE: begin
            if (unmapped) begin
               err_state_d = ERR_FIRST;
            end
         end
         ERR_FIRST: begin
            err_state_d = ERR_SECOND;   // Master holds its address here
         end
         ERR_SECOND: begin
            // hready is back so a new address phase may start here
            err_state_d = unmapped ? ERR_FIRST : ERR_IDLE;
         end
         default: begin
            err_state_d = ERR_IDLE;
         end
      endcase
   end

   always_ff @(posedge hclk_i) begin
      if (reset_i) begin
         err_state_q <= ERR_IDLE;
      end else begin
         err_state_q <= err_state_d;
      end
   end

   assign err_state_o = err_state_q;

endmodule

// File: hw/ahb_timer.sv
// One timer peripheral on an AHB-Lite slot
// Register bank (CTRL, COMPARE, COUNT, STATUS), free-running counter,
// compare match and interrupt

`timescale 1ns/1ps

module ahb_timer (
   input  logic              hclk_i,
   input  logic              reset_i,
   input  ahb_pkg::ahb_req_t req_i,
   input  ahb_pkg::hdata_t   hwdata_i,
   output ahb_pkg::hdata_t   rdata_o,
   output logic              irq_o
);

   import ahb_pkg::*;
   import timer_pkg::*;

   ahb_req_t  req_q;        // Request held for the data phase
   reg_sel_e  sel_q;
   logic      wr_en;

   tmr_ctrl_t ctrl_q;
   hdata_t    compare_q;
   hdata_t    count_q;
   logic      pending_q;
   logic      match;

   ////////////////////////////////////////////////////////////////////////////
   // Data-phase capture

   // Decoder has already qualified sel with transfer type and HREADY
   always_ff @(posedge hclk_i) begin
      if (reset_i) begin
         req_q <= '0;
      end else begin
         req_q <= req_i;
      end
   end

   assign sel_q = reg_sel_e'(req_q.word);
   assign wr_en = req_q.sel & req_q.write;

   ////////////////////////////////////////////////////////////////////////////
   // Registers

   always_ff @(posedge hclk_i) begin
      if (reset_i) begin
         ctrl_q    <= '0;
         compare_q <= '1;          // Match as late as possible
      end else if (wr_en) begin
         case (sel_q)
            CTRL: begin
               ctrl_q.enable <= hwdata_i[0];
               ctrl_q.irq_en <= hwdata_i[1];
            end
            COMPARE: begin
               compare_q <= hwdata_i;
            end
            default: begin
            end
         endcase
      end
   end

   assign match = ctrl_q.enable && (count_q == compare_q);

   // Counter where a bus write takes priority over counting
   always_ff @(posedge hclk_i) begin
      if (reset_i) begin
         count_q <= '0;
      end else if (wr_en && sel_q == COUNT) begin
         count_q <= hwdata_i;
      end else if (match) begin
         count_q <= '0;            // Wrap at COMPARE
      end else if (ctrl_q.enable) begin
         count_q <= count_q + 1'b1;
      end
   end

   // Pending flag where write-one-to-clear beats a match
   always_ff @(posedge hclk_i) begin
      if (reset_i) begin
         pending_q <= 1'b0;
      end else if (wr_en && sel_q == STATUS && hwdata_i[0]) begin
         pending_q <= 1'b0;
      end else if (match) begin
         pending_q <= 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Read data and interrupt

   always_comb begin
      rdata_o = '0;
      case (sel_q)
         CTRL:    rdata_o = hdata_t'(ctrl_q);
         COMPARE: rdata_o = compare_q;
         COUNT:   rdata_o = count_q;
         STATUS:  rdata_o = hdata_t'(pending_q);
         default: rdata_o = '0;
      endcase
   end

   assign irq_o = pending_q & ctrl_q.irq_en;

endmodule

// File: hw/soc_cfg.svh
// Timer subsystem build constants
// Slot count, bus widths, slot address map, register word offsets

`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// Bus
`define HADDR_W     32
`define HDATA_W     32

// Timer slots with a 16-byte window each
`define TMR_SLOTS   4
`define TMR_BASE    32'h4000_0000   // Slot 0 base
`define TMR_STRIDE  32'h0000_0100   // Distance between slot bases
`define TMR_MASK    32'hFFFF_FFF0   // Window mask

// Register offsets inside a window
`define REG_CTRL    32'h0
`define REG_COMPARE 32'h4
`define REG_COUNT   32'h8
`define REG_STATUS  32'hC

`endif

// File: hw/timer_pkg.sv
// Timer register types
// Register select, control word layout, slot index

`include "soc_cfg.svh"

package timer_pkg;

   // Word address inside the window picks the register
   typedef enum logic [1:0] {
      CTRL    = 2'((`REG_CTRL) >> 2),
      COMPARE = 2'((`REG_COMPARE) >> 2),
      COUNT   = 2'((`REG_COUNT) >> 2),
      STATUS  = 2'((`REG_STATUS) >> 2)
   } reg_sel_e;

   // CTRL register
   typedef struct packed {
      logic [`HDATA_W-3:0] rsvd;     // Reads as zero
      logic                irq_en;   // Bit 1
      logic                enable;   // Bit 0
   } tmr_ctrl_t;

   typedef logic [$clog2(`TMR_SLOTS)-1:0] slot_idx_t;

endpackage

// File: hw/timer_subsys_top.sv
// Timer subsystem top level
// Slot decoder, generate loop of timers, response mux

`timescale 1ns/1ps
`include "soc_cfg.svh"

module timer_subsys_top (
   input  logic                  hclk_i,
   input  logic                  reset_i,
   input  ahb_pkg::haddr_t       haddr_i,
   input  ahb_pkg::htrans_e      htrans_i,
   input  logic                  hwrite_i,
   input  ahb_pkg::hdata_t       hwdata_i,
   output ahb_pkg::hdata_t       hrdata_o,
   output logic                  hready_o,
   output logic                  hresp_o,
   output logic [`TMR_SLOTS-1:0] irq_o
);

   import ahb_pkg::*;

   ahb_req_t              slot_req   [`TMR_SLOTS];
   hdata_t                slot_rdata [`TMR_SLOTS];
   logic [`TMR_SLOTS-1:0] slot_hit;     // Accepted address phase, one-hot
   err_state_e            err_state;

   ahb_slot_decoder inst_decoder (
      .hclk_i      ( hclk_i    ),
      .reset_i     ( reset_i   ),
      .haddr_i     ( haddr_i   ),
      .htrans_i    ( htrans_i  ),
      .hwrite_i    ( hwrite_i  ),
      .hready_i    ( hready_o  ),    // HREADY fed back from the mux
      .slot_req_o  ( slot_req  ),
      .slot_hit_o  ( slot_hit  ),
      .err_state_o ( err_state ) );

   for (genvar i = 0; i < `TMR_SLOTS; i++) begin : g_timer
      ahb_timer inst_timer (
         .hclk_i   ( hclk_i        ),
         .reset_i  ( reset_i       ),
         .req_i    ( slot_req[i]   ),
         .hwdata_i ( hwdata_i      ),
         .rdata_o  ( slot_rdata[i] ),
         .irq_o    ( irq_o[i]      ) );
   end

   ahb_resp_mux inst_resp_mux (
      .hclk_i       ( hclk_i     ),
      .reset_i      ( reset_i    ),
      .slot_hit_i   ( slot_hit   ),
      .err_state_i  ( err_state  ),
      .slot_rdata_i ( slot_rdata ),
      .hrdata_o     ( hrdata_o   ),
      .hready_o     ( hready_o   ),
      .hresp_o      ( hresp_o    ) );

endmodule

// File: test/tb_timer_subsys.sv
// Testbench for the AHB-Lite timer subsystem
// Clock and reset, test data reader, bus driver, timeout and closing summary

`timescale 1ns/1ps
`include "soc_cfg.svh"

module tb_timer_subsys;

   import ahb_pkg::*;

   // One line of the test data file
   typedef struct packed {
      logic [7:0]  kind;
      haddr_t      addr;
      hdata_t      wdata;
      hdata_t      exp;
      logic [31:0] limit;
   } op_t;

   logic                  hclk;
   logic                  reset;
   haddr_t                haddr;
   htrans_e               htrans;
   logic                  hwrite;
   hdata_t                hwdata;
   hdata_t                hrdata;
   logic                  hready;
   logic                  hresp;
   logic [`TMR_SLOTS-1:0] irq;

   op_t  ops[$];
   op_t  cur_op;
   logic op_start;
   logic op_done;
   int   pass_cnt;
   int   fail_cnt;
   int   cycle_cnt   = 0;
   int   cycle_limit = 0;

   timer_subsys_top uut (
      .hclk_i   ( hclk   ),
      .reset_i  ( reset  ),
      .haddr_i  ( haddr  ),
      .htrans_i ( htrans ),
      .hwrite_i ( hwrite ),
      .hwdata_i ( hwdata ),
      .hrdata_o ( hrdata ),
      .hready_o ( hready ),
      .hresp_o  ( hresp  ),
      .irq_o    ( irq    ) );

   timer_checker chk (
      .hclk_i     ( hclk         ),
      .reset_i    ( reset        ),
      .op_start_i ( op_start     ),
      .op_kind_i  ( cur_op.kind  ),
      .op_addr_i  ( cur_op.addr  ),
      .op_exp_i   ( cur_op.exp   ),
      .op_limit_i ( cur_op.limit ),
      .htrans_i   ( htrans       ),
      .hready_i   ( hready       ),
      .hresp_i    ( hresp        ),
      .hrdata_i   ( hrdata       ),
      .irq_i      ( irq          ),
      .op_done_o  ( op_done      ),
      .pass_cnt_o ( pass_cnt     ),
      .fail_cnt_o ( fail_cnt     ) );

   initial begin
      hclk = 1'b0;
      forever begin
         #4 hclk = ~hclk;          // 8 ns period
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Test data

   task automatic load_ops(output logic ok);
      int          fd;
      int          c;
      int          max_wait;
      logic        bad;
      haddr_t      a;
      hdata_t      w;
      hdata_t      e;
      int          l;
      ok       = 1'b0;
      bad      = 1'b0;
      max_wait = 0;
      fd = $fopen("test/timer_testdata.txt", "r");
      if (fd != 0) begin
         c = $fgetc(fd);
         while (c != -1) begin
            if (c == "#") begin
               while (c != "\n" && c != -1) begin
                  c = $fgetc(fd);
               end
            end else if (c == "W" || c == "R" || c == "E" || c == "I") begin
               if ($fscanf(fd, "%h %h %h %d", a, w, e, l) == 4) begin
                  ops.push_back('{kind: 8'(c), addr: a, wdata: w, exp: e, limit: l});
                  max_wait = (l > max_wait) ? l : max_wait;
               end else begin
                  $display("Malformed line in the test data file");
                  bad = 1'b1;
               end
            end
            c = $fgetc(fd);
         end
         $fclose(fd);
         ok          = !bad && ops.size() > 0;
         cycle_limit = ops.size() * (max_wait + 4) + 20;
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Bus driver

   task automatic run_op(input op_t op);
      @(negedge hclk);
      cur_op   = op;
      op_start = 1'b1;             // Checker latches the expectation
      @(negedge hclk);
      op_start = 1'b0;
      if (op.kind != "I") begin
         haddr  = op.addr;
         htrans = NONSEQ;
         hwrite = (op.kind == "W") || (op.kind == "E" && op.exp[0]);
         do @(posedge hclk); while (!hready);
         @(negedge hclk);
         htrans = IDLE;            // Data phase
         hwdata = op.wdata;
      end
      do @(posedge hclk); while (!op_done);
   endtask

   initial begin
      logic loaded;
      reset    = 1'b1;
      haddr    = '0;
      htrans   = IDLE;
      hwrite   = 1'b0;
      hwdata   = '0;
      op_start = 1'b0;
      cur_op   = '0;
      load_ops(loaded);
      if (loaded) begin
         repeat (2) @(posedge hclk);
         @(negedge hclk);
         reset = 1'b0;
         foreach (ops[i]) begin
            run_op(ops[i]);
         end
         repeat (2) @(posedge hclk);
      end else begin
         $display("Could not read the test data file");
      end
      $display("%0d tests, %0d passed, %0d failed", ops.size(), pass_cnt, fail_cnt);
      if (loaded && fail_cnt == 0 && pass_cnt == ops.size()) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

   // Run limit from the number of lines and the longest wait
   initial begin
      wait (cycle_limit > 0);
      while (cycle_cnt < cycle_limit) begin
         @(posedge hclk);
         cycle_cnt++;
      end
      $display("Timeout, the run did not finish within %0d cycles", cycle_limit);
      $display("Verification failed");
      $finish;
   end

endmodule

// File: test/timer_checker.sv
// Checker for the timer subsystem testbench
// Follows each operation on the DUT ports, prints one result line per test

`timescale 1ns/1ps
`include "soc_cfg.svh"

module timer_checker (
   input  logic                  hclk_i,
   input  logic                  reset_i,
   input  logic                  op_start_i,
   input  logic [7:0]            op_kind_i,
   input  ahb_pkg::haddr_t       op_addr_i,
   input  ahb_pkg::hdata_t       op_exp_i,
   input  logic [31:0]           op_limit_i,
   input  ahb_pkg::htrans_e      htrans_i,
   input  logic                  hready_i,
   input  logic                  hresp_i,
   input  ahb_pkg::hdata_t       hrdata_i,
   input  logic [`TMR_SLOTS-1:0] irq_i,
   output logic                  op_done_o,
   output int                    pass_cnt_o,
   output int                    fail_cnt_o
);

   import ahb_pkg::*;

   typedef enum logic [2:0] {
      C_IDLE,
      C_ADDR,     // Waiting for the accepted address phase
      C_DATA,
      C_ERR2,     // Second cycle of an ERROR response
      C_IRQ
   } chk_state_e;

   chk_state_e  state;
   logic [7:0]  kind_q;
   haddr_t      addr_q;
   hdata_t      exp_q;
   logic [31:0] limit_q;
   int          cycles;
   int          test_no;
   logic        ok;

   function automatic logic check_val(input string name, input hdata_t got, input hdata_t exp);
      if (got !== exp) begin
         $display("error %s: got %h expected %h", name, got, exp);
         return 1'b0;
      end
      return 1'b1;
   endfunction

   task automatic close_op(input logic passed);
      if (passed) begin
         pass_cnt_o <= pass_cnt_o + 1;
      end else begin
         fail_cnt_o <= fail_cnt_o + 1;
      end
      $display("test %0d %s %h: %s", test_no, kind_q, addr_q, passed ? "ok" : "FAILED");
      op_done_o <= 1'b1;
      state     <= C_IDLE;
   endtask

   always @(posedge hclk_i) begin
      op_done_o <= 1'b0;
      if (reset_i) begin
         state      <= C_IDLE;
         pass_cnt_o <= 0;
         fail_cnt_o <= 0;
         test_no    <= 0;
      end else begin
         case (state)
            C_IDLE: begin
               if (op_start_i) begin
                  kind_q  <= op_kind_i;
                  addr_q  <= op_addr_i;
                  exp_q   <= op_exp_i;
                  limit_q <= op_limit_i;
                  cycles  <= 0;
                  test_no <= test_no + 1;
                  state   <= (op_kind_i == "I") ? C_IRQ : C_ADDR;
               end
            end
            C_ADDR: begin
               if (hready_i && htrans_i == NONSEQ) begin
                  state <= C_DATA;
               end
            end
            C_DATA: begin
               if (kind_q == "E") begin
                  ok = check_val("hready_o", 32'(hready_i), 32'h0);
                  ok = check_val("hresp_o", 32'(hresp_i), 32'h1) && ok;
                  if (ok) begin
                     state <= C_ERR2;
                  end else begin
                     close_op(1'b0);
                  end
               end else if (!hready_i) begin
                  $display("Mapped access at %h got a wait state", addr_q);
                  close_op(1'b0);
               end else begin
                  ok = check_val("hresp_o", 32'(hresp_i), 32'h0);
                  if (kind_q == "R" && limit_q != 0 && hrdata_i > exp_q) begin
                     $display("error hrdata_o: got %h above bound %h", hrdata_i, exp_q);
                     ok = 1'b0;
                  end else if (kind_q == "R" && limit_q == 0) begin
                     ok = check_val("hrdata_o", hrdata_i, exp_q) && ok;
                  end
                  close_op(ok);
               end
            end
            C_ERR2: begin
               ok = check_val("hready_o", 32'(hready_i), 32'h1);
               ok = check_val("hresp_o", 32'(hresp_i), 32'h1) && ok;
               close_op(ok);
            end
            C_IRQ: begin
               cycles <= cycles + 1;
               if ((irq_i & ~exp_q[`TMR_SLOTS-1:0]) != '0) begin
                  ok = check_val("irq_o", 32'(irq_i), exp_q);
                  close_op(1'b0);
               end else if (exp_q != '0 && irq_i == exp_q[`TMR_SLOTS-1:0]) begin
                  close_op(1'b1);
               end else if (cycles + 1 >= limit_q) begin
                  if (exp_q != '0) begin
                     $display("Interrupt %h did not rise within %0d cycles", exp_q, limit_q);
                  end
                  close_op(exp_q == '0);
               end
            end
            default: begin
               state <= C_IDLE;
            end
         endcase
      end
   end

endmodule

// File: test/timer_testdata.txt
# kind addr wdata expected limit; hex fields, limit in decimal cycles
# R with limit 1 takes expected as an upper bound, E drives HWRITE from expected bit 0
# I waits up to limit cycles for irq_o == expected, expected 0 means irq_o stays 0
R 40000000 00000000 00000000 0
R 40000004 00000000 FFFFFFFF 0
R 40000008 00000000 00000000 0
R 4000000C 00000000 00000000 0
R 40000100 00000000 00000000 0
R 40000108 00000000 00000000 0
R 4000010C 00000000 00000000 0
R 40000200 00000000 00000000 0
R 4000020C 00000000 00000000 0
R 40000300 00000000 00000000 0
R 4000030C 00000000 00000000 0
I 00000000 00000000 00000000 2
W 40000004 00001234 00000000 0
W 40000100 FFFFFFFE 00000000 0
W 40000204 0000ABCD 00000000 0
R 40000004 00000000 00001234 0
R 40000100 00000000 00000002 0
R 40000104 00000000 FFFFFFFF 0
R 40000204 00000000 0000ABCD 0
R 40000304 00000000 FFFFFFFF 0
E 40000010 11111111 00000001 0
E 50000000 00000000 00000000 0
R 40000004 00000000 00001234 0
W 40000208 00000777 00000000 0
R 40000208 00000000 00000777 0
W 40000200 00000001 00000000 0
R 40000208 00000000 0000ABCD 1
W 40000304 00000005 00000000 0
W 40000300 00000003 00000000 0
I 00000000 00000000 00000008 8
W 40000300 00000002 00000000 0
W 4000030C 00000001 00000000 0
I 00000000 00000000 00000000 2
R 4000030C 00000000 00000000 0
W 40000004 00000004 00000000 0
W 40000000 00000001 00000000 0
I 00000000 00000000 00000000 7
R 4000000C 00000000 00000001 0
